// ==== Makefile ====
# Verilator build and run for the branch predictor testbench

TOP  := tb_branch_predictor
SIM  := obj_dir/V$(TOP)
SRCS := $(wildcard design/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): branch_predictor.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) \
		-f branch_predictor.f -o V$(TOP)

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "All checks passed" sim.log; then \
		echo "Simulation ended without completing"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== branch_predictor.f ====
design/bp_pkg.sv
design/bp_btb.sv
design/bp_gshare_pht.sv
design/bp_global_history.sv
design/branch_predictor.sv
tests/tb_branch_predictor.sv

// ==== design/bp_btb.sv ====
// Direct-mapped branch target buffer with full-PC tags, targets, kinds and valid bits
`timescale 1ns/1ps

module bp_btb #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // Lookup from fetch
    input  logic [bp_pkg::XLEN-1:0]  lookup_pc_i,
    output logic                     hit_o,
    output bp_pkg::br_kind_t         kind_o,
    output logic [bp_pkg::XLEN-1:0]  target_o,

    // Write from execute
    input  logic                     wr_en_i,
    input  logic [bp_pkg::XLEN-1:0]  wr_pc_i,
    input  logic [6:0]               wr_op_i,
    input  logic [bp_pkg::XLEN-1:0]  wr_target_i
);

    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);

    // Entry storage
    logic [XLEN-1:0]      target_q [NUM_BTB_ENTRIES];
    logic [XLEN-1:0]      tag_q    [NUM_BTB_ENTRIES];
    br_kind_t             kind_q   [NUM_BTB_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0]  lookup_idx;
    logic [IDX_BITS-1:0]  wr_idx;
    br_kind_t             wr_kind;
    logic                 wr_fire;

    // Word-aligned PCs, so bits [1:0] are skipped
    assign lookup_idx = lookup_pc_i[IDX_BITS+1:2];
    assign wr_idx     = wr_pc_i[IDX_BITS+1:2];

    // Non control-flow opcodes never allocate
    assign wr_kind = decode_kind(wr_op_i);
    assign wr_fire = wr_en_i && (wr_kind != BR_NONE);

    // Lookup is purely combinational
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_pc_i);
    assign kind_o   = kind_q[lookup_idx];
    assign target_o = target_q[lookup_idx];

    // Valid bits
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wr_fire) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Payload arrays, overwritten on every allocating write
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            target_q[wr_idx] <= wr_target_i;
            tag_q[wr_idx]    <= wr_pc_i;
            kind_q[wr_idx]   <= wr_kind;
        end
    end

    // A hit must come from an entry that was installed with a real kind
    a_hit_has_kind: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        hit_o |-> (kind_o != BR_NONE)
    ) else $error("BTB hit on entry with kind BR_NONE");

    // Fetch PC must be known whenever the BTB is looked up
    a_lookup_idx_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(lookup_idx)
    ) else $error("BTB lookup index is unknown");

endmodule

// ==== design/bp_global_history.sv ====
// Speculative and committed global history registers with restore on mispredict
`timescale 1ns/1ps

module bp_global_history #(
    parameter int NUM_GHR_BITS = 5
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // Fetch-time speculative shift
    input  logic                     spec_shift_i,
    input  logic                     spec_bit_i,

    // Resolved branch from execute
    input  logic                     commit_i,
    input  logic                     commit_bit_i,
    input  logic                     restore_i,

    output logic [NUM_GHR_BITS-1:0]  ghr_o
);

    logic [NUM_GHR_BITS-1:0] spec_q;
    logic [NUM_GHR_BITS-1:0] commit_q;
    logic [NUM_GHR_BITS-1:0] commit_next;

    // Newest outcome enters at bit 0
    assign commit_next = {commit_q[NUM_GHR_BITS-2:0], commit_bit_i};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_q <= '0;
        end else if (commit_i) begin
            commit_q <= commit_next;
        end
    end

    // Restore wins over a fetch shift in the same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spec_q <= '0;
        end else if (restore_i) begin
            spec_q <= commit_next;
        end else if (spec_shift_i) begin
            spec_q <= {spec_q[NUM_GHR_BITS-2:0], spec_bit_i};
        end
    end

    assign ghr_o = spec_q;

    // A restore is only meaningful together with the commit it copies from
    a_restore_needs_commit: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        restore_i |-> commit_i
    ) else $error("History restore without commit");

endmodule

// ==== design/bp_gshare_pht.sv ====
// Gshare pattern history table of 2-bit saturating counters with read index and update
`timescale 1ns/1ps

module bp_gshare_pht #(
    parameter int NUM_GHR_BITS = 5
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // Prediction side
    input  logic [bp_pkg::XLEN-1:0]  pc_i,
    input  logic [NUM_GHR_BITS-1:0]  ghr_i,
    output logic [NUM_GHR_BITS-1:0]  read_index_o,
    output logic                     taken_o,

    // Training side
    input  logic                     upd_en_i,
    input  logic [NUM_GHR_BITS-1:0]  upd_index_i,
    input  logic                     upd_taken_i
);

    import bp_pkg::*;

    localparam int PHT_ENTRIES = 1 << NUM_GHR_BITS;

    ctr_t pht_q [PHT_ENTRIES];
    ctr_t upd_cur;
    ctr_t upd_next;

    // Gshare index
    assign read_index_o = pc_i[NUM_GHR_BITS+1:2] ^ ghr_i;
    assign taken_o      = pht_q[read_index_o][1];

    // Saturating step of the addressed counter
    assign upd_cur = pht_q[upd_index_i];

    always_comb begin
        upd_next = upd_cur;
        if (upd_taken_i) begin
            if (upd_cur != CTR_MAX) begin
                upd_next = upd_cur + 2'd1;
            end
        end else begin
            if (upd_cur != CTR_MIN) begin
                upd_next = upd_cur - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= CTR_RESET;
            end
        end else if (upd_en_i) begin
            pht_q[upd_index_i] <= upd_next;
        end
    end

    // Strongly taken stays strongly taken, no wrap to 00
    a_sat_high: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (upd_en_i && upd_taken_i && (upd_cur == CTR_MAX))
            |=> (pht_q[$past(upd_index_i)] == CTR_MAX)
    ) else $error("PHT counter wrapped past 11");

    // Strongly not taken stays put, no wrap to 11
    a_sat_low: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (upd_en_i && !upd_taken_i && (upd_cur == CTR_MIN))
            |=> (pht_q[$past(upd_index_i)] == CTR_MIN)
    ) else $error("PHT counter wrapped past 00");

endmodule

// ==== design/bp_pkg.sv ====
// Shared opcodes, branch kind encoding, counter type and reset constants for the predictor
package bp_pkg;

    // Architectural word width
    localparam int XLEN = 32;

    // RISC-V major opcodes of the control-flow instructions
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // Kind of control flow held by a BTB entry
    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_JUMP = 2'b01,
        BR_COND = 2'b10
    } br_kind_t;

    // 2-bit saturating counter
    // MSB set means predict taken
    typedef logic [1:0] ctr_t;

    // Weakly not taken
    localparam ctr_t CTR_RESET = 2'b01;

    // Counter bounds
    localparam ctr_t CTR_MAX = 2'b11;
    localparam ctr_t CTR_MIN = 2'b00;

    // Decode of an opcode into the kind stored in the BTB
    function automatic br_kind_t decode_kind(input logic [6:0] op);
        br_kind_t kind;
        kind = BR_NONE;
        if (op == OP_BRANCH) begin
            kind = BR_COND;
        end else if ((op == OP_JAL) || (op == OP_JALR)) begin
            kind = BR_JUMP;
        end
        return kind;
    endfunction

endpackage

// ==== design/branch_predictor.sv ====
// Branch predictor top joining BTB, gshare PHT and global history into taken and target
`timescale 1ns/1ps

module branch_predictor #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 5
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // Fetch side
    input  logic [bp_pkg::XLEN-1:0]  fetch_pc_i,
    input  logic                     fetch_valid_i,
    output logic                     pred_taken_o,
    output logic [bp_pkg::XLEN-1:0]  pred_target_o,
    output logic [NUM_GHR_BITS-1:0]  pred_pht_index_o,

    // Execute side
    input  logic                     upd_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  upd_pc_i,
    input  logic [6:0]               upd_op_i,
    input  logic [bp_pkg::XLEN-1:0]  upd_target_i,
    input  logic                     upd_taken_i,
    input  logic                     upd_mispredict_i,
    input  logic [NUM_GHR_BITS-1:0]  upd_pht_index_i
);

    import bp_pkg::*;

    logic                     btb_hit;
    br_kind_t                 btb_kind;
    logic [XLEN-1:0]          btb_target;
    logic                     pht_taken;
    logic [NUM_GHR_BITS-1:0]  spec_ghr;
    logic                     pred_is_cond;
    logic                     upd_is_branch;

    assign upd_is_branch = upd_valid_i && (upd_op_i == OP_BRANCH);
    assign pred_is_cond  = btb_hit && (btb_kind == BR_COND);

    // BTB filters non control-flow opcodes itself
    bp_btb #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES)
    ) btb_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lookup_pc_i (fetch_pc_i),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target),
        .wr_en_i     (upd_valid_i),
        .wr_pc_i     (upd_pc_i),
        .wr_op_i     (upd_op_i),
        .wr_target_i (upd_target_i)
    );

    bp_gshare_pht #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) pht_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pc_i         (fetch_pc_i),
        .ghr_i        (spec_ghr),
        .read_index_o (pred_pht_index_o),
        .taken_o      (pht_taken),
        .upd_en_i     (upd_is_branch),
        .upd_index_i  (upd_pht_index_i),
        .upd_taken_i  (upd_taken_i)
    );

    // History indexes the PHT beside it
    bp_global_history #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) ghr_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .spec_shift_i (fetch_valid_i && pred_is_cond),
        .spec_bit_i   (pred_taken_o),
        .commit_i     (upd_is_branch),
        .commit_bit_i (upd_taken_i),
        .restore_i    (upd_is_branch && upd_mispredict_i),
        .ghr_o        (spec_ghr)
    );

    // Miss falls through, jump always taken, conditional follows the counter
    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = fetch_pc_i + XLEN'(4);
        if (btb_hit) begin
            pred_target_o = btb_target;
            if (btb_kind == BR_JUMP) begin
                pred_taken_o = 1'b1;
            end else begin
                pred_taken_o = pht_taken;
            end
        end
    end

endmodule

// ==== tests/tb_branch_predictor.sv ====
// Testbench for the branch predictor with a reference model and checking assertions
`timescale 1ns/1ps

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int NUM_BTB_ENTRIES = 32;
    localparam int NUM_GHR_BITS    = 5;
    localparam int IDX_BITS        = $clog2(NUM_BTB_ENTRIES);
    localparam int PHT_ENTRIES     = 1 << NUM_GHR_BITS;
    localparam logic [6:0] OP_ALU  = 7'b0110011;

    logic                     clk;
    logic                     arst_n_i;
    logic [XLEN-1:0]          fetch_pc_i;
    logic                     fetch_valid_i;
    logic                     pred_taken_o;
    logic [XLEN-1:0]          pred_target_o;
    logic [NUM_GHR_BITS-1:0]  pred_pht_index_o;
    logic                     upd_valid_i;
    logic [XLEN-1:0]          upd_pc_i;
    logic [6:0]               upd_op_i;
    logic [XLEN-1:0]          upd_target_i;
    logic                     upd_taken_i;
    logic                     upd_mispredict_i;
    logic [NUM_GHR_BITS-1:0]  upd_pht_index_i;

    int seed;
    int assert_errors;
    int wait_timeouts;

    // Reference model state
    logic                     m_valid  [NUM_BTB_ENTRIES];
    logic [XLEN-1:0]          m_tag    [NUM_BTB_ENTRIES];
    logic [XLEN-1:0]          m_target [NUM_BTB_ENTRIES];
    br_kind_t                 m_kind   [NUM_BTB_ENTRIES];
    ctr_t                     m_ctr    [PHT_ENTRIES];
    logic [NUM_GHR_BITS-1:0]  m_spec;
    logic [NUM_GHR_BITS-1:0]  m_commit;

    logic [IDX_BITS-1:0]      exp_slot;
    logic                     exp_hit;
    logic                     exp_taken;
    logic [XLEN-1:0]          exp_target;
    logic [NUM_GHR_BITS-1:0]  exp_index;
    br_kind_t                 upd_kind;
    logic [NUM_GHR_BITS-1:0]  commit_after;

    branch_predictor #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES),
        .NUM_GHR_BITS    (NUM_GHR_BITS)
    ) dut_i (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_valid_i    (fetch_valid_i),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target_o),
        .pred_pht_index_o (pred_pht_index_o),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_op_i         (upd_op_i),
        .upd_target_i     (upd_target_i),
        .upd_taken_i      (upd_taken_i),
        .upd_mispredict_i (upd_mispredict_i),
        .upd_pht_index_i  (upd_pht_index_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Kind that an update installs, straight from the RISC-V opcode map
    always_comb begin
        case (upd_op_i)
            OP_BRANCH:       upd_kind = BR_COND;
            OP_JAL, OP_JALR: upd_kind = BR_JUMP;
            default:         upd_kind = BR_NONE;
        endcase
    end

    assign commit_after = {m_commit[NUM_GHR_BITS-2:0], upd_taken_i};

    // Expected prediction for the current fetch PC
    always_comb begin
        exp_slot   = fetch_pc_i[IDX_BITS+1:2];
        exp_hit    = m_valid[exp_slot] && (m_tag[exp_slot] == fetch_pc_i);
        exp_index  = fetch_pc_i[NUM_GHR_BITS+1:2] ^ m_spec;
        exp_taken  = 1'b0;
        exp_target = fetch_pc_i + 32'd4;
        if (exp_hit) begin
            exp_target = m_target[exp_slot];
            exp_taken  = (m_kind[exp_slot] == BR_JUMP) ? 1'b1 : m_ctr[exp_index][1];
        end
    end

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_BTB_ENTRIES; i++) begin
                m_valid[i] <= 1'b0;
            end
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                m_ctr[i] <= CTR_RESET;
            end
            m_spec   <= '0;
            m_commit <= '0;
        end else begin
            if (upd_valid_i && (upd_kind != BR_NONE)) begin
                m_valid[upd_pc_i[IDX_BITS+1:2]]  <= 1'b1;
                m_tag[upd_pc_i[IDX_BITS+1:2]]    <= upd_pc_i;
                m_target[upd_pc_i[IDX_BITS+1:2]] <= upd_target_i;
                m_kind[upd_pc_i[IDX_BITS+1:2]]   <= upd_kind;
            end
            if (upd_valid_i && (upd_kind == BR_COND)) begin
                if (upd_taken_i && (m_ctr[upd_pht_index_i] != 2'b11)) begin
                    m_ctr[upd_pht_index_i] <= m_ctr[upd_pht_index_i] + 2'd1;
                end else if (!upd_taken_i && (m_ctr[upd_pht_index_i] != 2'b00)) begin
                    m_ctr[upd_pht_index_i] <= m_ctr[upd_pht_index_i] - 2'd1;
                end
                m_commit <= commit_after;
            end
            // Mispredict restore beats a fetch shift
            if (upd_valid_i && (upd_kind == BR_COND) && upd_mispredict_i) begin
                m_spec <= commit_after;
            end else if (fetch_valid_i && exp_hit && (m_kind[exp_slot] == BR_COND)) begin
                m_spec <= {m_spec[NUM_GHR_BITS-2:0], exp_taken};
            end
        end
    end

    a_taken_matches: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pred_taken_o == exp_taken
    ) else begin
        assert_errors++;
        $display("[FAIL] %0t: pred_taken_o is %0b, expected %0b for pc %h", $time,
                 $sampled(pred_taken_o), $sampled(exp_taken), $sampled(fetch_pc_i));
    end

    a_target_matches: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pred_target_o == exp_target
    ) else begin
        assert_errors++;
        $display("[FAIL] %0t: pred_target_o is %h, expected %h for pc %h", $time,
                 $sampled(pred_target_o), $sampled(exp_target), $sampled(fetch_pc_i));
    end

    a_index_matches: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pred_pht_index_o == exp_index
    ) else begin
        assert_errors++;
        $display("[FAIL] %0t: pred_pht_index_o is %h, expected %h for pc %h", $time,
                 $sampled(pred_pht_index_o), $sampled(exp_index), $sampled(fetch_pc_i));
    end

    task automatic advance(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic set_fetch(input logic [XLEN-1:0] pc, input logic valid);
        fetch_pc_i    = pc;
        fetch_valid_i = valid;
    endtask

    // One-cycle training strobe from execute
    task automatic pulse_update(input logic [XLEN-1:0] pc, input logic [6:0] op,
                                input logic [XLEN-1:0] target, input logic taken,
                                input logic mispredict, input logic [NUM_GHR_BITS-1:0] index);
        upd_valid_i      = 1'b1;
        upd_pc_i         = pc;
        upd_op_i         = op;
        upd_target_i     = target;
        upd_taken_i      = taken;
        upd_mispredict_i = mispredict;
        upd_pht_index_i  = index;
        advance(1);
        upd_valid_i      = 1'b0;
        upd_mispredict_i = 1'b0;
    endtask

    task automatic read_index(output logic [NUM_GHR_BITS-1:0] index);
        @(negedge clk);
        index = pred_pht_index_o;
        advance(1);
    endtask

    task automatic wait_taken(input logic expected, input int max_cycles, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while ((pred_taken_o !== expected) && (n < max_cycles)) begin
            @(negedge clk);
            n++;
        end
        if (pred_taken_o !== expected) begin
            wait_timeouts++;
            $display("Timed out after %0d cycles waiting for %s", max_cycles, what);
        end
        advance(1);
    endtask

    // Word-aligned PCs in a small window so that entries alias and get reused
    task automatic pick_pc(output logic [XLEN-1:0] pc);
        pc = 32'h0000_1000 + ((32'($random(seed)) & 32'h0000_00FF) << 2);
    endtask

    initial begin
        logic [XLEN-1:0]         pc;
        logic [XLEN-1:0]         pc_b;
        logic [XLEN-1:0]         pc_c;
        logic [NUM_GHR_BITS-1:0] idx0;
        int                      i;
        int                      r;

        seed             = 43107;
        assert_errors    = 0;
        wait_timeouts    = 0;
        arst_n_i         = 1'b0;
        fetch_pc_i       = 32'h0000_1000;
        fetch_valid_i    = 1'b0;
        upd_valid_i      = 1'b0;
        upd_pc_i         = '0;
        upd_op_i         = OP_ALU;
        upd_target_i     = '0;
        upd_taken_i      = 1'b0;
        upd_mispredict_i = 1'b0;
        upd_pht_index_i  = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        advance(1);

        // Cold misses
        for (i = 0; i < 24; i++) begin
            pick_pc(pc);
            set_fetch(pc, 1'b1);
            advance(1);
        end

        // Jump install, then an ALU op that must not allocate
        set_fetch(32'h0000_2000, 1'b0);
        pulse_update(32'h0000_2000, OP_JAL, 32'h0000_2400, 1'b1, 1'b0, '0);
        wait_taken(1'b1, 4, "JAL entry to predict taken");
        set_fetch(32'h0000_2010, 1'b0);
        pulse_update(32'h0000_2010, OP_JALR, 32'h0000_3800, 1'b1, 1'b0, '0);
        wait_taken(1'b1, 4, "JALR entry to predict taken");
        set_fetch(32'h0000_2020, 1'b0);
        pulse_update(32'h0000_2020, OP_ALU, 32'h0000_2800, 1'b1, 1'b0, '0);
        wait_taken(1'b0, 4, "ALU op to stay a miss");

        // Counter training at the captured index
        pc_b = 32'h0000_3000;
        set_fetch(pc_b, 1'b0);
        read_index(idx0);
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b1, 1'b0, idx0);
        wait_taken(1'b1, 4, "branch to predict taken after one taken update");
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b1, 1'b0, idx0);
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b1, 1'b0, idx0);
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b0, 1'b0, idx0);
        wait_taken(1'b1, 4, "saturated branch to stay taken after one not-taken update");
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b0, 1'b0, idx0);
        wait_taken(1'b0, 4, "branch to flip back to not taken");
        // Drive the counter down to the floor and once more past it
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b0, 1'b0, idx0);
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b0, 1'b0, idx0);

        // Same slot, different tag
        pc_c = pc_b + 32'(NUM_BTB_ENTRIES * 4);
        set_fetch(pc_c, 1'b0);
        advance(1);
        pulse_update(pc_c, OP_JAL, 32'h0000_5000, 1'b1, 1'b0, '0);
        wait_taken(1'b1, 4, "replacing JAL entry to hit");
        set_fetch(pc_b, 1'b0);
        advance(2);

        // Speculative history shifts on branch fetches, then a mispredict restores it
        read_index(idx0);
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b1, 1'b0, idx0);
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b1, 1'b0, idx0);
        wait_taken(1'b1, 4, "reinstalled branch to predict taken");
        set_fetch(pc_b, 1'b1);
        advance(6);
        pulse_update(pc_b, OP_BRANCH, 32'h0000_3100, 1'b1, 1'b1, idx0);
        set_fetch(pc_b, 1'b0);
        advance(3);

        // Random mix of fetches and updates
        for (i = 0; i < 400; i++) begin
            pick_pc(pc);
            set_fetch(pc, 1'($random(seed)));
            r = $random(seed);
            upd_valid_i = ((r & 3) == 0);
            r = $random(seed);
            case (r & 3)
                0:       upd_op_i = OP_BRANCH;
                1:       upd_op_i = OP_JAL;
                2:       upd_op_i = OP_JALR;
                default: upd_op_i = OP_ALU;
            endcase
            pick_pc(upd_pc_i);
            pick_pc(upd_target_i);
            upd_taken_i      = 1'($random(seed));
            upd_mispredict_i = 1'($random(seed));
            upd_pht_index_i  = NUM_GHR_BITS'($random(seed));
            advance(1);
        end
        upd_valid_i      = 1'b0;
        upd_mispredict_i = 1'b0;
        fetch_valid_i    = 1'b0;
        advance(2);

        $display("Assertion errors: %0d, wait timeouts: %0d", assert_errors, wait_timeouts);
        if ((assert_errors == 0) && (wait_timeouts == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog for the whole run
    initial begin
        #50000;
        $display("Simulation did not finish the test sequence in time");
        $display("Checks failed");
        $finish;
    end

endmodule
